/* Makefile */
TOP = core_bus_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q '^TEST OK$$'

clean:
	rm -rf obj_dir

/* verif/core_bus_chk.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_bus_params.svh"

module core_bus_chk (
	input logic                    clock,
	input logic                    rst_n,
	input logic                    arvalid,
	input logic                    arready,
	input logic [`CORE_BUS_AW-1:0] araddr,
	input logic                    rvalid,
	input logic                    rready,
	input logic                    awvalid,
	input logic                    awready,
	input logic [`CORE_BUS_AW-1:0] awaddr,
	input logic                    wvalid,
	input logic                    wready,
	input logic [31:0]             wdata,
	input logic [3:0]              wstrb,
	input logic                    fetch_done,
	input logic                    mem_done
);

	int   violations;
	logic rd_open;

	initial begin
		violations = 0;
	end

	// a read is open from its AR handshake until its R handshake
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			rd_open <= 1'b0;
		end else if (arvalid && arready) begin
			rd_open <= 1'b1;
		end else if (rvalid && rready) begin
			rd_open <= 1'b0;
		end
	end

	ar_hold: assert property (@(posedge clock) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else begin
			violations++;
			$error("AR channel changed before arready");
		end

	aw_hold: assert property (@(posedge clock) disable iff (!rst_n)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else begin
			violations++;
			$error("AW channel changed before awready");
		end

	w_hold: assert property (@(posedge clock) disable iff (!rst_n)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
		else begin
			violations++;
			$error("W channel changed before wready");
		end

	ar_single: assert property (@(posedge clock) disable iff (!rst_n)
		rd_open |-> !arvalid)
		else begin
			violations++;
			$error("arvalid raised while a read is outstanding");
		end

	fetch_pulse: assert property (@(posedge clock) disable iff (!rst_n)
		fetch_done |=> !fetch_done)
		else begin
			violations++;
			$error("fetch_done held longer than one cycle");
		end

	mem_pulse: assert property (@(posedge clock) disable iff (!rst_n)
		mem_done |=> !mem_done)
		else begin
			violations++;
			$error("mem_done held longer than one cycle");
		end

endmodule

bind core_bus_top core_bus_chk chk_i (.*);

`default_nettype wire

/* verif/core_bus_tb_params.svh */
`ifndef CORE_BUS_TB_PARAMS_SVH
`define CORE_BUS_TB_PARAMS_SVH

// external memory, loads and stores use the lower 4 KB and fetches the upper 4 KB
`define MEM_BASE 32'h8000_0000
`define MEM_WORDS 2048

// every access to this page ends with SLVERR
`define SLVERR_PAGE 32'h4000_0000

// initial contents, mixed from the full byte address of the word
`define MEM_HASH(a) ((((a) ^ 32'h6b8b_4567) * 32'h9e37_79b1) ^ ((a) >> 11))

`endif

/* verif/core_bus_scoreboard.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_bus_params.svh"
`include "core_bus_tb_params.svh"

module core_bus_scoreboard
	import core_bus_pkg::*;
(
	input  logic        clock,
	input  logic        rst_n,
	input  logic        fetch_req,
	input  logic [31:0] fetch_addr,
	input  logic        fetch_done,
	input  logic [31:0] fetch_inst,
	input  logic        fetch_err,
	input  logic        mem_req,
	input  logic        mem_we,
	input  logic        mem_unsigned,
	input  mem_size_t   mem_size,
	input  logic [31:0] mem_addr,
	input  logic [31:0] mem_wdata,
	input  logic        mem_done,
	input  logic [31:0] mem_rdata,
	input  logic        mem_err,
	output int          error_count,
	output int          fetch_count,
	output int          mem_count
);

	logic [31:0] shadow [0:`MEM_WORDS-1];
	logic        f_busy;
	logic [31:0] f_addr;
	int          f_age;
	logic        l_busy;
	logic        l_we;
	logic        l_uns;
	mem_size_t   l_size;
	logic [31:0] l_addr;
	logic [31:0] l_wdata;
	int          l_age;
	logic [63:0] cycles;
	logic [31:0] last_mtime;

	initial begin
		error_count = 0;
		fetch_count = 0;
		mem_count   = 0;
		for (int i = 0; i < `MEM_WORDS; i++) begin
			shadow[i] = `MEM_HASH(`MEM_BASE + 32'(i * 4));
		end
	end

	function automatic logic hits(input logic [31:0] a, input logic [31:0] base,
		input logic [31:0] mask);
		return (a & mask) == base;
	endfunction

	function automatic logic misaligned(input mem_size_t size, input logic [31:0] a);
		case (size)
			BYTE:    return 1'b0;
			HALF:    return a[0];
			default: return a[1:0] != 2'b00;
		endcase
	endfunction

	function automatic logic [31:0] extend_load(input logic [31:0] word, input logic [1:0] ofs,
		input mem_size_t size, input logic uns);
		logic [7:0]  b;
		logic [15:0] h;
		b = word[ofs*8 +: 8];
		h = ofs[1] ? word[31:16] : word[15:0];
		case (size)
			BYTE:    return uns ? {24'h0, b} : {{24{b[7]}}, b};
			HALF:    return uns ? {16'h0, h} : {{16{h[15]}}, h};
			default: return word;
		endcase
	endfunction

	function automatic logic [31:0] merge_store(input logic [31:0] word, input logic [1:0] ofs,
		input mem_size_t size, input logic [31:0] wd);
		logic [31:0] r;
		r = word;
		case (size)
			BYTE:    r[ofs*8 +: 8] = wd[7:0];
			HALF:    r[ofs[1]*16 +: 16] = wd[15:0];
			default: r = wd;
		endcase
		return r;
	endfunction

	task automatic mismatch(input string name, input logic [31:0] got, input string expected);
		error_count++;
		$display("CHECK FAILED at %0t: %s = %h, expected %s", $time, name, got, expected);
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			mismatch(name, got, $sformatf("%h", exp));
		end
	endtask

	task automatic complain(input string what);
		error_count++;
		$display("ERROR at %0t: %s", $time, what);
	endtask

	task automatic check_fetch();
		fetch_count++;
		f_busy = 1'b0;
		if (f_addr[1:0] != 2'b00) begin
			compare("fetch_err", 32'(fetch_err), 32'h1);
			compare("fetch_done latency", 32'(f_age), 32'd1);
		end else if (hits(f_addr, `ERR_BASE, `ERR_MASK)) begin
			compare("fetch_err", 32'(fetch_err), 32'h1);
			compare("fetch_done latency", 32'(f_age), 32'd2);
		end else begin
			compare("fetch_err", 32'(fetch_err), 32'h0);
			compare("fetch_inst", fetch_inst, `MEM_HASH(f_addr));
		end
	endtask

	task automatic check_mem();
		logic [31:0] word;
		mem_count++;
		l_busy = 1'b0;
		word = shadow[l_addr[12:2]];
		if (misaligned(l_size, l_addr) || hits(l_addr, `ERR_BASE, `ERR_MASK) ||
			(l_we && hits(l_addr, `CLINT_BASE, `CLINT_MASK))) begin
			compare("mem_err", 32'(mem_err), 32'h1);
			compare("mem_done latency", 32'(l_age), 32'd2);
		end else if (hits(l_addr, `CLINT_BASE, `CLINT_MASK)) begin
			compare("mem_err", 32'(mem_err), 32'h0);
			if (l_age < 3) begin
				mismatch("mem_done latency", 32'(l_age), "at least 3");
			end
			if (l_addr[2]) begin
				compare("mem_rdata", mem_rdata, cycles[63:32]);
			end else begin
				if (mem_rdata <= last_mtime) begin
					mismatch("mem_rdata", mem_rdata, $sformatf("above %h", last_mtime));
				end
				if ({32'h0, mem_rdata} > cycles) begin
					mismatch("mem_rdata", mem_rdata, $sformatf("at most %h", cycles[31:0]));
				end
				last_mtime = mem_rdata;
			end
		end else if (hits(l_addr, `SLVERR_PAGE, 32'hffff_f000)) begin
			compare("mem_err", 32'(mem_err), 32'h1);
		end else if (hits(l_addr, `MEM_BASE, 32'hffff_e000)) begin
			compare("mem_err", 32'(mem_err), 32'h0);
			if (l_we) begin
				shadow[l_addr[12:2]] = merge_store(word, l_addr[1:0], l_size, l_wdata);
			end else begin
				compare("mem_rdata", mem_rdata, extend_load(word, l_addr[1:0], l_size, l_uns));
			end
		end else begin
			complain("load/store went to an address the memory model does not map");
		end
	endtask

	// outputs are sampled before the edge updates them, inputs were set on the falling edge
	always @(posedge clock) begin
		if (!rst_n) begin
			f_busy     = 1'b0;
			l_busy     = 1'b0;
			cycles     = 64'd0;
			last_mtime = 32'h0;
		end else begin
			cycles = cycles + 64'd1;
			f_age++;
			l_age++;
			if (fetch_done) begin
				if (f_busy) begin
					check_fetch();
				end else begin
					complain("fetch_done arrived with no fetch pending");
				end
			end
			if (fetch_req) begin
				if (f_busy) begin
					complain("fetch request issued while the previous one was pending");
				end
				f_busy = 1'b1;
				f_addr = fetch_addr;
				f_age  = 0;
			end
			if (mem_done) begin
				if (l_busy) begin
					check_mem();
				end else begin
					complain("mem_done arrived with no load/store pending");
				end
			end
			if (mem_req) begin
				if (l_busy) begin
					complain("load/store issued while the previous one was pending");
				end
				l_busy  = 1'b1;
				l_we    = mem_we;
				l_uns   = mem_unsigned;
				l_size  = mem_size;
				l_addr  = mem_addr;
				l_wdata = mem_wdata;
				l_age   = 0;
			end
		end
	end

endmodule

`default_nettype wire

/* verif/core_bus_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_bus_params.svh"
`include "core_bus_tb_params.svh"

module core_bus_tb
	import core_bus_pkg::*;
();

	localparam int FETCHES  = 400;
	localparam int ACCESSES = 400;

	logic                    clock = 1'b0;
	logic                    rst_n;
	logic                    fetch_req;
	logic [31:0]             fetch_addr;
	logic                    fetch_done;
	logic [31:0]             fetch_inst;
	logic                    fetch_err;
	logic                    mem_req;
	logic                    mem_we;
	logic                    mem_unsigned;
	mem_size_t               mem_size;
	logic [`CORE_BUS_AW-1:0] mem_addr;
	logic [31:0]             mem_wdata;
	logic                    mem_done;
	logic [31:0]             mem_rdata;
	logic                    mem_err;
	logic                    arvalid;
	logic                    arready;
	logic [`CORE_BUS_AW-1:0] araddr;
	logic                    rvalid;
	logic                    rready;
	logic [31:0]             rdata;
	logic [1:0]              rresp;
	logic                    awvalid;
	logic                    awready;
	logic [`CORE_BUS_AW-1:0] awaddr;
	logic                    wvalid;
	logic                    wready;
	logic [31:0]             wdata;
	logic [3:0]              wstrb;
	logic                    bvalid;
	logic                    bready;
	logic [1:0]              bresp;

	int          sb_errors;
	int          fetches_done;
	int          accesses_done;
	int          errors;
	logic [31:0] ext_mem [0:`MEM_WORDS-1];
	logic        ar_hs;
	logic        r_hs;
	logic        aw_hs;
	logic        w_hs;
	logic        b_hs;
	logic [31:0] ar_addr_q;
	logic [31:0] aw_addr_q;
	logic [31:0] w_data_q;
	logic [3:0]  w_strb_q;
	logic        r_busy;
	logic        aw_have;
	logic        w_have;
	logic        b_busy;
	int          r_wait;
	int          b_wait;

	core_bus_top dut_i (.*);

	core_bus_scoreboard sb_i (
		.error_count(sb_errors),
		.fetch_count(fetches_done),
		.mem_count  (accesses_done),
		.*
	);

	initial begin
		forever #5 clock = ~clock;
	end

	function automatic logic [1:0] decode_resp(input logic [31:0] a);
		if ((a & 32'hffff_f000) == `SLVERR_PAGE) return SLVERR;
		if ((a & 32'hffff_e000) == `MEM_BASE) return OKAY;
		return DECERR;
	endfunction

	task automatic store_word(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
		int b;
		for (b = 0; b < 4; b++) begin
			if (s[b]) begin
				ext_mem[a[12:2]][b*8 +: 8] = d[b*8 +: 8];
			end
		end
	endtask

	// handshakes are seen at the rising edge and acted on at the next falling edge
	always @(posedge clock) begin
		ar_hs <= arvalid && arready;
		r_hs  <= rvalid && rready;
		aw_hs <= awvalid && awready;
		w_hs  <= wvalid && wready;
		b_hs  <= bvalid && bready;
		if (arvalid && arready) ar_addr_q <= araddr;
		if (awvalid && awready) aw_addr_q <= awaddr;
		if (wvalid && wready) begin
			w_data_q <= wdata;
			w_strb_q <= wstrb;
		end
	end

	always @(negedge clock) begin
		if (!rst_n) begin
			r_busy  = 1'b0;
			aw_have = 1'b0;
			w_have  = 1'b0;
			b_busy  = 1'b0;
		end else begin
			if (r_hs) rvalid = 1'b0;
			if (ar_hs) begin
				r_busy = 1'b1;
				r_wait = $urandom_range(0, 3);
			end
			if (r_busy && !rvalid) begin
				if (r_wait > 0) begin
					r_wait--;
				end else begin
					r_busy = 1'b0;
					rvalid = 1'b1;
					rresp  = decode_resp(ar_addr_q);
					rdata  = (rresp == OKAY) ? ext_mem[ar_addr_q[12:2]] : 32'h0;
				end
			end
			if (b_hs) bvalid = 1'b0;
			if (aw_hs) aw_have = 1'b1;
			if (w_hs) w_have = 1'b1;
			if (aw_have && w_have) begin
				aw_have = 1'b0;
				w_have  = 1'b0;
				bresp   = decode_resp(aw_addr_q);
				if (bresp == OKAY) store_word(aw_addr_q, w_data_q, w_strb_q);
				b_busy = 1'b1;
				b_wait = $urandom_range(0, 3);
			end
			if (b_busy && !bvalid) begin
				if (b_wait > 0) begin
					b_wait--;
				end else begin
					b_busy = 1'b0;
					bvalid = 1'b1;
				end
			end
			arready = ($urandom_range(0, 3) != 0);
			awready = ($urandom_range(0, 3) != 0);
			wready  = ($urandom_range(0, 3) != 0);
		end
	end

	task automatic run_fetches(input int count);
		logic [31:0] addr;
		int          pick;
		int          i;
		for (i = 0; i < count; i++) begin
			pick = $urandom_range(0, 15);
			addr = `MEM_BASE + 32'h1000 + ($urandom & 32'hffc);
			if (pick == 0) begin
				addr = `ERR_BASE + ($urandom & 32'hffc);
			end else if (pick < 3) begin
				addr[1:0] = 2'($urandom_range(1, 3));
			end
			@(negedge clock);
			fetch_req  = 1'b1;
			fetch_addr = addr;
			@(negedge clock);
			fetch_req = 1'b0;
			while (!fetch_done) @(negedge clock);
			repeat ($urandom_range(0, 2)) @(negedge clock);
		end
	endtask

	task automatic run_accesses(input int count);
		logic [31:0] addr;
		mem_size_t   size;
		int          pick;
		int          i;
		for (i = 0; i < count; i++) begin
			pick = $urandom_range(0, 19);
			size = mem_size_t'($urandom_range(0, 2));
			// a small window so loads often meet earlier stores
			addr = `MEM_BASE + ($urandom & 32'hff);
			if ($urandom_range(0, 3) != 0) addr = addr & ~((32'd1 << size) - 32'd1);
			if (pick == 0) begin
				addr = `ERR_BASE + ($urandom & 32'hffc);
			end else if (pick == 1) begin
				addr = `SLVERR_PAGE + ($urandom & 32'hffc);
			end else if (pick < 5) begin
				addr = `CLINT_BASE + ($urandom & 32'h4);
				size = WORD;
			end
			@(negedge clock);
			mem_req      = 1'b1;
			mem_we       = 1'($urandom_range(0, 1));
			mem_unsigned = 1'($urandom_range(0, 1));
			mem_size     = size;
			mem_addr     = addr;
			mem_wdata    = $urandom;
			@(negedge clock);
			mem_req = 1'b0;
			while (!mem_done) @(negedge clock);
			repeat ($urandom_range(0, 2)) @(negedge clock);
		end
	endtask

	initial begin
		repeat ((FETCHES + ACCESSES) * 200) @(posedge clock);
		$display("watchdog expired before all requests completed");
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'h04d1_9d5f));
		rst_n        = 1'b0;
		fetch_req    = 1'b0;
		fetch_addr   = 32'h0;
		mem_req      = 1'b0;
		mem_we       = 1'b0;
		mem_unsigned = 1'b0;
		mem_size     = WORD;
		mem_addr     = 32'h0;
		mem_wdata    = 32'h0;
		arready      = 1'b0;
		rvalid       = 1'b0;
		rdata        = 32'h0;
		rresp        = 2'b00;
		awready      = 1'b0;
		wready       = 1'b0;
		bvalid       = 1'b0;
		bresp        = 2'b00;
		for (int i = 0; i < `MEM_WORDS; i++) begin
			ext_mem[i] = `MEM_HASH(`MEM_BASE + 32'(i * 4));
		end
		repeat (4) @(negedge clock);
		rst_n = 1'b1;
		fork
			run_fetches(FETCHES);
			run_accesses(ACCESSES);
		join
		repeat (5) @(negedge clock);
		errors = sb_errors + dut_i.chk_i.violations;
		$display("fetches %0d/%0d, accesses %0d/%0d, check errors %0d, assertion errors %0d",
			fetches_done, FETCHES, accesses_done, ACCESSES, sb_errors,
			dut_i.chk_i.violations);
		if (errors == 0 && fetches_done == FETCHES && accesses_done == ACCESSES) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+verilog
+incdir+verif
verilog/core_bus_pkg.sv
verilog/req_hold.sv
verilog/fetch_port.sv
verilog/lsu_port.sv
verilog/bus_xbar.sv
verilog/clint_timer.sv
verilog/core_bus_top.sv
verif/core_bus_chk.sv
verif/core_bus_scoreboard.sv
verif/core_bus_tb.sv

/* verilog/bus_xbar.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_bus_params.svh"

module bus_xbar
	import core_bus_pkg::*;
(
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    f_rd_valid,
	output logic                    f_rd_ready,
	input  logic [`CORE_BUS_AW-1:0] f_rd_addr,
	output logic                    f_rsp_valid,
	output logic [31:0]             f_rsp_data,
	output bus_resp_t               f_rsp_resp,
	input  logic                    l_rd_valid,
	output logic                    l_rd_ready,
	input  logic [`CORE_BUS_AW-1:0] l_rd_addr,
	input  logic                    l_wr_valid,
	output logic                    l_wr_ready,
	input  logic [`CORE_BUS_AW-1:0] l_wr_addr,
	input  logic [31:0]             l_wr_data,
	input  logic [3:0]              l_wr_strb,
	output logic                    l_rsp_valid,
	output logic [31:0]             l_rsp_data,
	output bus_resp_t               l_rsp_resp,
	output logic                    timer_rd,
	output logic                    timer_sel,
	input  logic [31:0]             timer_data,
	output logic                    arvalid,
	input  logic                    arready,
	output logic [`CORE_BUS_AW-1:0] araddr,
	input  logic                    rvalid,
	output logic                    rready,
	input  logic [31:0]             rdata,
	input  logic [1:0]              rresp,
	output logic                    awvalid,
	input  logic                    awready,
	output logic [`CORE_BUS_AW-1:0] awaddr,
	output logic                    wvalid,
	input  logic                    wready,
	output logic [31:0]             wdata,
	output logic [3:0]              wstrb,
	input  logic                    bvalid,
	output logic                    bready,
	input  logic [1:0]              bresp
);

	typedef enum logic [1:0] {RD_IDLE, RD_CLINT, RD_ADDR, RD_DATA} rd_state_t;

	rd_state_t               rd_state;
	logic                    rd_owner_lsu;
	logic                    wr_busy;
	logic                    f_err_hit;
	logic                    l_err_hit;
	logic                    w_err_hit;
	logic                    w_clint_hit;
	logic                    f_grant;
	logic                    l_grant;
	logic [`CORE_BUS_AW-1:0] grant_addr;
	logic                    grant_clint;
	logic                    rd_done;
	logic [31:0]             rd_rsp_data;
	bus_resp_t               rd_rsp_resp;
	logic                    l_wr_take;
	logic                    l_wr_ext;
	logic                    b_take;

	function automatic logic in_window(input logic [`CORE_BUS_AW-1:0] addr,
		input logic [`CORE_BUS_AW-1:0] base, input logic [`CORE_BUS_AW-1:0] mask);
		return (addr & mask) == base;
	endfunction

	assign f_err_hit   = in_window(f_rd_addr, `ERR_BASE, `ERR_MASK);
	assign l_err_hit   = in_window(l_rd_addr, `ERR_BASE, `ERR_MASK);
	assign w_err_hit   = in_window(l_wr_addr, `ERR_BASE, `ERR_MASK);
	assign w_clint_hit = in_window(l_wr_addr, `CLINT_BASE, `CLINT_MASK);

	// error window reads bypass the single read slot, the load/store port wins ties
	assign l_grant    = (rd_state == RD_IDLE) && l_rd_valid && !l_err_hit;
	assign f_grant    = (rd_state == RD_IDLE) && f_rd_valid && !f_err_hit && !l_grant;
	assign f_rd_ready = f_err_hit || f_grant;
	assign l_rd_ready = l_err_hit || l_grant;

	assign grant_addr  = l_grant ? l_rd_addr : f_rd_addr;
	assign grant_clint = in_window(grant_addr, `CLINT_BASE, `CLINT_MASK);
	assign timer_rd    = (f_grant || l_grant) && grant_clint;
	assign timer_sel   = grant_addr[2];

	assign arvalid     = (rd_state == RD_ADDR);
	assign rready      = (rd_state == RD_DATA);
	assign rd_done     = (rd_state == RD_CLINT) || (rvalid && rready);
	assign rd_rsp_data = (rd_state == RD_CLINT) ? timer_data : rdata;
	assign rd_rsp_resp = (rd_state == RD_CLINT) ? OKAY : bus_resp_t'(rresp);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			rd_state     <= RD_IDLE;
			rd_owner_lsu <= 1'b0;
		end else begin
			case (rd_state)
				RD_IDLE: if (f_grant || l_grant) begin
					rd_owner_lsu <= l_grant;
					rd_state     <= grant_clint ? RD_CLINT : RD_ADDR;
				end
				RD_CLINT: rd_state <= RD_IDLE;
				RD_ADDR:  if (arready) rd_state <= RD_DATA;
				default:  if (rvalid) rd_state <= RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (f_grant || l_grant) begin
			araddr <= grant_addr;
		end
	end

	assign l_wr_ready = w_err_hit || w_clint_hit || !wr_busy;
	assign l_wr_take  = l_wr_valid && l_wr_ready;
	assign l_wr_ext   = l_wr_take && !w_err_hit && !w_clint_hit;
	assign bready     = wr_busy && !awvalid && !wvalid;
	assign b_take     = bvalid && bready;

	// AW and W go up together but each drops on its own ready
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wr_busy <= 1'b0;
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
		end else if (l_wr_ext) begin
			wr_busy <= 1'b1;
			awvalid <= 1'b1;
			wvalid  <= 1'b1;
		end else begin
			if (awready) awvalid <= 1'b0;
			if (wready) wvalid <= 1'b0;
			if (b_take) wr_busy <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (l_wr_ext) begin
			awaddr <= l_wr_addr;
			wdata  <= l_wr_data;
			wstrb  <= l_wr_strb;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			f_rsp_valid <= 1'b0;
			l_rsp_valid <= 1'b0;
		end else begin
			f_rsp_valid <= (f_rd_valid && f_err_hit) || (rd_done && !rd_owner_lsu);
			l_rsp_valid <= (l_rd_valid && l_err_hit) || (rd_done && rd_owner_lsu) ||
				(l_wr_take && !l_wr_ext) || b_take;
		end
	end

	always_ff @(posedge clock) begin
		if (f_rd_valid && f_err_hit) begin
			f_rsp_data <= 32'h0;
			f_rsp_resp <= DECERR;
		end else if (rd_done && !rd_owner_lsu) begin
			f_rsp_data <= rd_rsp_data;
			f_rsp_resp <= rd_rsp_resp;
		end
		if ((l_rd_valid && l_err_hit) || (l_wr_take && w_err_hit)) begin
			l_rsp_data <= 32'h0;
			l_rsp_resp <= DECERR;
		end else if (l_wr_take && w_clint_hit) begin
			l_rsp_data <= 32'h0;
			l_rsp_resp <= SLVERR;
		end else if (rd_done && rd_owner_lsu) begin
			l_rsp_data <= rd_rsp_data;
			l_rsp_resp <= rd_rsp_resp;
		end else if (b_take) begin
			l_rsp_data <= 32'h0;
			l_rsp_resp <= bus_resp_t'(bresp);
		end
	end

endmodule

`default_nettype wire

/* verilog/clint_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module clint_timer (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        timer_rd,
	input  logic        timer_sel,
	output logic [31:0] timer_data
);

	logic [63:0] mtime;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			mtime <= 64'd0;
		end else begin
			mtime <= mtime + 64'd1;
		end
	end

	// halves are read separately, software has to handle the carry between them
	always_ff @(posedge clock) begin
		if (timer_rd) begin
			timer_data <= timer_sel ? mtime[63:32] : mtime[31:0];
		end
	end

endmodule

`default_nettype wire

/* verilog/core_bus_params.svh */
`ifndef CORE_BUS_PARAMS_SVH
`define CORE_BUS_PARAMS_SVH

`define CORE_BUS_AW 32

// machine timer, low word at offset 0 and high word at offset 4
`define CLINT_BASE 32'h0200_0000
`define CLINT_MASK 32'hffff_fff0

// nothing lives here, the crossbar answers without touching the bus
`define ERR_BASE 32'h1000_0000
`define ERR_MASK 32'hffff_f000

`endif

/* verilog/core_bus_pkg.sv */
`default_nettype none

package core_bus_pkg;

	// same encoding as the AXI xRESP field, so bus responses cast straight across
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} bus_resp_t;

	typedef enum logic [1:0] {
		BYTE = 2'b00,
		HALF = 2'b01,
		WORD = 2'b10
	} mem_size_t;

	typedef struct packed {
		logic        we;
		logic        ld_unsigned;
		mem_size_t   size;
		logic [31:0] addr;
		logic [31:0] wdata;
	} lsu_req_t;

endpackage

`default_nettype wire

/* verilog/core_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_bus_params.svh"

module core_bus_top
	import core_bus_pkg::*;
(
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    fetch_req,
	input  logic [31:0]             fetch_addr,
	output logic                    fetch_done,
	output logic [31:0]             fetch_inst,
	output logic                    fetch_err,
	input  logic                    mem_req,
	input  logic                    mem_we,
	input  logic                    mem_unsigned,
	input  mem_size_t               mem_size,
	input  logic [`CORE_BUS_AW-1:0] mem_addr,
	input  logic [31:0]             mem_wdata,
	output logic                    mem_done,
	output logic [31:0]             mem_rdata,
	output logic                    mem_err,
	output logic                    arvalid,
	input  logic                    arready,
	output logic [`CORE_BUS_AW-1:0] araddr,
	input  logic                    rvalid,
	output logic                    rready,
	input  logic [31:0]             rdata,
	input  logic [1:0]              rresp,
	output logic                    awvalid,
	input  logic                    awready,
	output logic [`CORE_BUS_AW-1:0] awaddr,
	output logic                    wvalid,
	input  logic                    wready,
	output logic [31:0]             wdata,
	output logic [3:0]              wstrb,
	input  logic                    bvalid,
	output logic                    bready,
	input  logic [1:0]              bresp
);

	logic                    f_rd_valid;
	logic                    f_rd_ready;
	logic [`CORE_BUS_AW-1:0] f_rd_addr;
	logic                    f_rsp_valid;
	logic [31:0]             f_rsp_data;
	bus_resp_t               f_rsp_resp;
	logic                    l_rd_valid;
	logic                    l_rd_ready;
	logic [`CORE_BUS_AW-1:0] l_rd_addr;
	logic                    l_wr_valid;
	logic                    l_wr_ready;
	logic [`CORE_BUS_AW-1:0] l_wr_addr;
	logic [31:0]             l_wr_data;
	logic [3:0]              l_wr_strb;
	logic                    l_rsp_valid;
	logic [31:0]             l_rsp_data;
	bus_resp_t               l_rsp_resp;
	logic                    timer_rd;
	logic                    timer_sel;
	logic [31:0]             timer_data;

	fetch_port fetch_i (
		.rd_valid (f_rd_valid),
		.rd_ready (f_rd_ready),
		.rd_addr  (f_rd_addr),
		.rsp_valid(f_rsp_valid),
		.rsp_data (f_rsp_data),
		.rsp_resp (f_rsp_resp),
		.*
	);

	lsu_port lsu_i (
		.rd_valid (l_rd_valid),
		.rd_ready (l_rd_ready),
		.rd_addr  (l_rd_addr),
		.wr_valid (l_wr_valid),
		.wr_ready (l_wr_ready),
		.wr_addr  (l_wr_addr),
		.wr_data  (l_wr_data),
		.wr_strb  (l_wr_strb),
		.rsp_valid(l_rsp_valid),
		.rsp_data (l_rsp_data),
		.rsp_resp (l_rsp_resp),
		.*
	);

	bus_xbar xbar_i (.*);

	clint_timer timer_i (.*);

endmodule

`default_nettype wire

/* verilog/fetch_port.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_port
	import core_bus_pkg::*;
(
	input  logic        clock,
	input  logic        rst_n,
	input  logic        fetch_req,
	input  logic [31:0] fetch_addr,
	output logic        fetch_done,
	output logic [31:0] fetch_inst,
	output logic        fetch_err,
	output logic        rd_valid,
	input  logic        rd_ready,
	output logic [31:0] rd_addr,
	input  logic        rsp_valid,
	input  logic [31:0] rsp_data,
	input  bus_resp_t   rsp_resp
);

	logic aligned;
	logic mis_q;

	assign aligned = (fetch_addr[1:0] == 2'b00);

	req_hold #(
		.payload_t(logic [31:0])
	) hold_i (
		.clock    (clock),
		.rst_n    (rst_n),
		.load     (fetch_req && aligned),
		.load_data(fetch_addr),
		.take     (rd_valid && rd_ready),
		.valid    (rd_valid),
		.data     (rd_addr)
	);

	// a misaligned fetch never reaches the crossbar and is answered next cycle
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			mis_q <= 1'b0;
		end else begin
			mis_q <= fetch_req && !aligned;
		end
	end

	assign fetch_done = rsp_valid || mis_q;
	assign fetch_inst = mis_q ? 32'h0 : rsp_data;
	assign fetch_err  = mis_q || (rsp_valid && (rsp_resp != OKAY));

endmodule

`default_nettype wire

/* verilog/lsu_port.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_bus_params.svh"

module lsu_port
	import core_bus_pkg::*;
(
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    mem_req,
	input  logic                    mem_we,
	input  logic                    mem_unsigned,
	input  mem_size_t               mem_size,
	input  logic [`CORE_BUS_AW-1:0] mem_addr,
	input  logic [31:0]             mem_wdata,
	output logic                    mem_done,
	output logic [31:0]             mem_rdata,
	output logic                    mem_err,
	output logic                    rd_valid,
	input  logic                    rd_ready,
	output logic [`CORE_BUS_AW-1:0] rd_addr,
	output logic                    wr_valid,
	input  logic                    wr_ready,
	output logic [`CORE_BUS_AW-1:0] wr_addr,
	output logic [31:0]             wr_data,
	output logic [3:0]              wr_strb,
	input  logic                    rsp_valid,
	input  logic [31:0]             rsp_data,
	input  bus_resp_t               rsp_resp
);

	lsu_req_t    new_req;
	lsu_req_t    req;
	logic        held;
	logic        misaligned;
	logic [1:0]  mis_q;
	logic [31:0] lane;

	// undefined size codes are treated like a word
	always_comb begin
		case (mem_size)
			BYTE:    misaligned = 1'b0;
			HALF:    misaligned = mem_addr[0];
			default: misaligned = |mem_addr[1:0];
		endcase
	end

	assign new_req = '{we: mem_we, ld_unsigned: mem_unsigned, size: mem_size,
		addr: mem_addr, wdata: mem_wdata};

	req_hold #(
		.payload_t(lsu_req_t)
	) hold_i (
		.clock    (clock),
		.rst_n    (rst_n),
		.load     (mem_req && !misaligned),
		.load_data(new_req),
		.take     ((rd_valid && rd_ready) || (wr_valid && wr_ready)),
		.valid    (held),
		.data     (req)
	);

	assign rd_valid = held && !req.we;
	assign wr_valid = held && req.we;
	assign rd_addr  = req.addr;
	assign wr_addr  = req.addr;

	always_comb begin
		case (req.size)
			BYTE: begin
				wr_data = {4{req.wdata[7:0]}};
				wr_strb = 4'b0001 << req.addr[1:0];
			end
			HALF: begin
				wr_data = {2{req.wdata[15:0]}};
				wr_strb = 4'b0011 << req.addr[1:0];
			end
			default: begin
				wr_data = req.wdata;
				wr_strb = 4'b1111;
			end
		endcase
	end

	assign lane = rsp_data >> {req.addr[1:0], 3'b000};

	always_comb begin
		case (req.size)
			BYTE:    mem_rdata = {{24{lane[7] && !req.ld_unsigned}}, lane[7:0]};
			HALF:    mem_rdata = {{16{lane[15] && !req.ld_unsigned}}, lane[15:0]};
			default: mem_rdata = rsp_data;
		endcase
	end

	// two stages so a refused access lines up with the crossbar's own error answers
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			mis_q <= 2'b00;
		end else begin
			mis_q <= {mis_q[0], mem_req && misaligned};
		end
	end

	assign mem_done = rsp_valid || mis_q[1];
	assign mem_err  = mis_q[1] || (rsp_valid && (rsp_resp != OKAY));

endmodule

`default_nettype wire

/* verilog/req_hold.sv */
`timescale 1ns/1ps
`default_nettype none

module req_hold #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clock,
	input  logic     rst_n,
	input  logic     load,
	input  payload_t load_data,
	input  logic     take,
	output logic     valid,
	output payload_t data
);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			valid <= 1'b0;
		end else if (load) begin
			valid <= 1'b1;
		end else if (take) begin
			valid <= 1'b0;
		end
	end

	// data outlives valid so the port can still format the response
	always_ff @(posedge clock) begin
		if (load) begin
			data <= load_data;
		end
	end

endmodule

`default_nettype wire
